/* src/desc_dma_consts.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, depths and marker values for the descriptor DMA frontend.
// Include it wherever a width or a queue depth is needed.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DESC_DMA_CONSTS_SVH
`define DESC_DMA_CONSTS_SVH

// memory address width
`define DESC_ADDR_W 32
// byte length of one burst
`define DESC_LEN_W 24
// descriptor flags field
`define DESC_FLAGS_W 8
// flags bit that asks for an irq on completion
`define DESC_IRQ_BIT 0

// queue depths
`define DESC_ADDR_Q_DEPTH 4
`define DESC_REQ_Q_DEPTH 4

// next field value that terminates a chain
`define DESC_END_OF_CHAIN {`DESC_ADDR_W{1'b1}}
// written over the flags word once a descriptor is done
`define DESC_DONE_MARK {`DESC_FLAGS_W{1'b1}}

`endif

/* src/desc_dma_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the descriptor DMA frontend.
// Modules refer to these by scoped name.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "desc_dma_consts.svh"

package desc_dma_pkg;

    typedef logic [`DESC_ADDR_W-1:0] addr_t;

    // in-memory layout, fetched as one 128 bit beat
    // flags sit in the top byte so write-back only touches that word
    typedef struct packed {
        logic [`DESC_FLAGS_W-1:0] flags;
        logic [`DESC_LEN_W-1:0]   length;
        addr_t                    next;
        addr_t                    src_addr;
        addr_t                    dst_addr;
    } descriptor_t;

    // one copy request for the backend
    typedef struct packed {
        addr_t                  src_addr;
        addr_t                  dst_addr;
        logic [`DESC_LEN_W-1:0] length;
    } burst_req_t;

    // request buffer entry
    // desc_addr is where the completion marker goes
    typedef struct packed {
        burst_req_t burst;
        addr_t      desc_addr;
        logic       irq;
    } pending_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ISSUE,
        FETCH_WAIT,
        FETCH_PUSH
    } fetch_state_e;

    typedef enum logic [1:0] {
        CPL_IDLE,
        CPL_SUBMIT,
        CPL_WAIT,
        CPL_WRITEBACK
    } cpl_state_e;

endpackage

`default_nettype wire

/* src/desc_queue.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO with valid/ready on both sides and a full level.
// Not fall-through. Used for the address queue and the request buffer.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module desc_queue #(
    parameter type         T     = logic,
    parameter int unsigned DEPTH = 4
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic push_valid_i,
    input  wire T     push_data_i,
    output logic      push_ready_o,
    output logic      pop_valid_o,
    output T          pop_data_o,
    input  wire logic pop_ready_i,
    output logic      full_o
);

    // pointer needs at least one bit even for a single entry
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign full_o       = (count_q == FULL_CNT);
    assign push_ready_o = ~full_o;
    assign pop_valid_o  = (count_q != '0);
    // head of the queue, valid one cycle after its push
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign push = push_valid_i & push_ready_o;
    assign pop  = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // wrap explicitly so odd depths work too
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // head entry holds while the consumer stalls
    a_pop_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_data_o));

    // a producer refused on full keeps offering the same entry
    a_push_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i));

endmodule

`default_nettype wire

/* src/desc_fetcher.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Descriptor fetcher. Pops a queued address, reads the descriptor, pushes a
// request entry and follows next until the end of the chain.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "desc_dma_consts.svh"

module desc_fetcher (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    // queued descriptor addresses
    input  wire logic                     addr_valid_i,
    input  wire logic [`DESC_ADDR_W-1:0]  addr_i,
    output logic                          addr_ready_o,
    // memory read port
    output logic                          mem_rd_valid_o,
    output logic [`DESC_ADDR_W-1:0]       mem_rd_addr_o,
    input  wire logic                     mem_rd_ready_i,
    input  wire logic                     mem_rd_rsp_valid_i,
    input  wire desc_dma_pkg::descriptor_t mem_rd_rsp_i,
    // request buffer push side
    output logic                          req_valid_o,
    output desc_dma_pkg::pending_t        req_o,
    input  wire logic                     req_ready_i,
    output logic                          busy_o
);

    desc_dma_pkg::fetch_state_e state_q;
    desc_dma_pkg::fetch_state_e state_d;
    // address of the descriptor in flight
    logic [`DESC_ADDR_W-1:0]    addr_q;
    desc_dma_pkg::descriptor_t  desc_q;
    logic                       last_desc;
    logic                       rsp_take;

    assign last_desc = (desc_q.next == `DESC_END_OF_CHAIN);
    assign rsp_take  = (state_q == desc_dma_pkg::FETCH_WAIT) && mem_rd_rsp_valid_i;

    assign mem_rd_addr_o = addr_q;
    assign busy_o        = (state_q != desc_dma_pkg::FETCH_IDLE);

    // entry built straight from the registered descriptor
    always_comb begin
        req_o.burst.src_addr = desc_q.src_addr;
        req_o.burst.dst_addr = desc_q.dst_addr;
        req_o.burst.length   = desc_q.length;
        req_o.desc_addr      = addr_q;
        req_o.irq            = desc_q.flags[`DESC_IRQ_BIT];
    end

    always_comb begin
        state_d        = state_q;
        addr_ready_o   = 1'b0;
        mem_rd_valid_o = 1'b0;
        req_valid_o    = 1'b0;
        case (state_q)
            desc_dma_pkg::FETCH_IDLE: begin
                // take a new chain head
                addr_ready_o = 1'b1;
                if (addr_valid_i) begin
                    state_d = desc_dma_pkg::FETCH_ISSUE;
                end
            end
            desc_dma_pkg::FETCH_ISSUE: begin
                mem_rd_valid_o = 1'b1;
                if (mem_rd_ready_i) begin
                    state_d = desc_dma_pkg::FETCH_WAIT;
                end
            end
            desc_dma_pkg::FETCH_WAIT: begin
                // single read outstanding
                if (mem_rd_rsp_valid_i) begin
                    state_d = desc_dma_pkg::FETCH_PUSH;
                end
            end
            desc_dma_pkg::FETCH_PUSH: begin
                // a full buffer stalls the chain walk here
                req_valid_o = 1'b1;
                if (req_ready_i) begin
                    state_d = last_desc ? desc_dma_pkg::FETCH_IDLE
                                        : desc_dma_pkg::FETCH_ISSUE;
                end
            end
            default: begin
                state_d = desc_dma_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= desc_dma_pkg::FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        // chain head from the queue, or the next link after a push
        if (addr_ready_o && addr_valid_i) begin
            addr_q <= addr_i;
        end else if (req_valid_o && req_ready_i && !last_desc) begin
            addr_q <= desc_q.next;
        end
        if (rsp_take) begin
            desc_q <= mem_rd_rsp_i;
        end
    end

    // memory answers only the read we are waiting on
    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rd_rsp_valid_i |-> state_q == desc_dma_pkg::FETCH_WAIT);

endmodule

`default_nettype wire

/* src/desc_completion.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion unit. Hands one buffered request at a time to the backend,
// writes the done marker over the flags word, then pulses the irq.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "desc_dma_consts.svh"

module desc_completion (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    // request buffer pop side
    input  wire logic                    req_valid_i,
    input  wire desc_dma_pkg::pending_t  req_i,
    output logic                         req_ready_o,
    // backend
    output logic                         dma_req_valid_o,
    output desc_dma_pkg::burst_req_t     dma_req_o,
    input  wire logic                    dma_req_ready_i,
    input  wire logic                    dma_done_i,
    // marker write-back
    output logic                         mem_wb_valid_o,
    output logic [`DESC_ADDR_W-1:0]      mem_wb_addr_o,
    output logic [`DESC_FLAGS_W-1:0]     mem_wb_data_o,
    input  wire logic                    mem_wb_ready_i,
    output logic                         irq_o,
    output logic                         busy_o
);

    desc_dma_pkg::cpl_state_e state_q;
    desc_dma_pkg::cpl_state_e state_d;
    // entry being worked on
    desc_dma_pkg::pending_t   entry_q;
    logic                     irq_q;
    logic                     wb_done;

    assign wb_done = mem_wb_valid_o && mem_wb_ready_i;

    assign dma_req_o     = entry_q.burst;
    assign mem_wb_addr_o = entry_q.desc_addr;
    assign mem_wb_data_o = `DESC_DONE_MARK;
    assign irq_o         = irq_q;
    // irq cycle still counts as activity
    assign busy_o        = (state_q != desc_dma_pkg::CPL_IDLE) || irq_q;

    always_comb begin
        state_d         = state_q;
        req_ready_o     = 1'b0;
        dma_req_valid_o = 1'b0;
        mem_wb_valid_o  = 1'b0;
        case (state_q)
            desc_dma_pkg::CPL_IDLE: begin
                req_ready_o = 1'b1;
                if (req_valid_i) begin
                    state_d = desc_dma_pkg::CPL_SUBMIT;
                end
            end
            desc_dma_pkg::CPL_SUBMIT: begin
                // held until the backend takes it
                dma_req_valid_o = 1'b1;
                if (dma_req_ready_i) begin
                    state_d = desc_dma_pkg::CPL_WAIT;
                end
            end
            desc_dma_pkg::CPL_WAIT: begin
                if (dma_done_i) begin
                    state_d = desc_dma_pkg::CPL_WRITEBACK;
                end
            end
            desc_dma_pkg::CPL_WRITEBACK: begin
                mem_wb_valid_o = 1'b1;
                if (mem_wb_ready_i) begin
                    state_d = desc_dma_pkg::CPL_IDLE;
                end
            end
            default: begin
                state_d = desc_dma_pkg::CPL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= desc_dma_pkg::CPL_IDLE;
            irq_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // one cycle pulse after the marker lands
            irq_q   <= wb_done && entry_q.irq;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_ready_o && req_valid_i) begin
            entry_q <= req_i;
        end
    end

    // backend finishes only the burst it was given
    a_done_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dma_done_i |-> state_q == desc_dma_pkg::CPL_WAIT);

endmodule

`default_nettype wire

/* src/desc_dma_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Descriptor DMA frontend top. Address queue, fetcher, request buffer and
// completion unit, plus the busy and queue full status levels.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "desc_dma_consts.svh"

module desc_dma_top (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    // descriptor address register
    input  wire logic                     desc_addr_we_i,
    input  wire logic [`DESC_ADDR_W-1:0]  desc_addr_i,
    output logic                          queue_full_o,
    output logic                          busy_o,
    // descriptor read
    output logic                          mem_rd_valid_o,
    output logic [`DESC_ADDR_W-1:0]       mem_rd_addr_o,
    input  wire logic                     mem_rd_ready_i,
    input  wire logic                     mem_rd_rsp_valid_i,
    input  wire desc_dma_pkg::descriptor_t mem_rd_rsp_i,
    // done marker write
    output logic                          mem_wb_valid_o,
    output logic [`DESC_ADDR_W-1:0]       mem_wb_addr_o,
    output logic [`DESC_FLAGS_W-1:0]      mem_wb_data_o,
    input  wire logic                     mem_wb_ready_i,
    // backend
    output logic                          dma_req_valid_o,
    output desc_dma_pkg::burst_req_t      dma_req_o,
    input  wire logic                     dma_req_ready_i,
    input  wire logic                     dma_done_i,
    output logic                          irq_o
);

    logic                    addr_q_ready;
    logic                    addr_q_valid;
    desc_dma_pkg::addr_t     addr_q_data;
    logic                    addr_q_pop;
    logic                    fetch_busy;
    logic                    push_valid;
    desc_dma_pkg::pending_t  push_data;
    logic                    push_ready;
    logic                    req_q_valid;
    desc_dma_pkg::pending_t  req_q_data;
    logic                    req_q_pop;
    logic                    cpl_busy;

    // a write into a full queue is dropped here
    // so the queue never sees a refused push
    desc_queue #(
        .T     (desc_dma_pkg::addr_t),
        .DEPTH (`DESC_ADDR_Q_DEPTH)
    ) u_addr_q (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (desc_addr_we_i && addr_q_ready),
        .push_data_i  (desc_addr_i),
        .push_ready_o (addr_q_ready),
        .pop_valid_o  (addr_q_valid),
        .pop_data_o   (addr_q_data),
        .pop_ready_i  (addr_q_pop),
        .full_o       (queue_full_o)
    );

    desc_fetcher u_fetcher (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .addr_valid_i       (addr_q_valid),
        .addr_i             (addr_q_data),
        .addr_ready_o       (addr_q_pop),
        .mem_rd_valid_o     (mem_rd_valid_o),
        .mem_rd_addr_o      (mem_rd_addr_o),
        .mem_rd_ready_i     (mem_rd_ready_i),
        .mem_rd_rsp_valid_i (mem_rd_rsp_valid_i),
        .mem_rd_rsp_i       (mem_rd_rsp_i),
        .req_valid_o        (push_valid),
        .req_o              (push_data),
        .req_ready_i        (push_ready),
        .busy_o             (fetch_busy)
    );

    desc_queue #(
        .T     (desc_dma_pkg::pending_t),
        .DEPTH (`DESC_REQ_Q_DEPTH)
    ) u_req_q (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (push_valid),
        .push_data_i  (push_data),
        .push_ready_o (push_ready),
        .pop_valid_o  (req_q_valid),
        .pop_data_o   (req_q_data),
        .pop_ready_i  (req_q_pop),
        .full_o       ()
    );

    desc_completion u_completion (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_q_valid),
        .req_i           (req_q_data),
        .req_ready_o     (req_q_pop),
        .dma_req_valid_o (dma_req_valid_o),
        .dma_req_o       (dma_req_o),
        .dma_req_ready_i (dma_req_ready_i),
        .dma_done_i      (dma_done_i),
        .mem_wb_valid_o  (mem_wb_valid_o),
        .mem_wb_addr_o   (mem_wb_addr_o),
        .mem_wb_data_o   (mem_wb_data_o),
        .mem_wb_ready_i  (mem_wb_ready_i),
        .irq_o           (irq_o),
        .busy_o          (cpl_busy)
    );

    // any stage still holding work
    assign busy_o = addr_q_valid | fetch_busy | req_q_valid | cpl_busy;

endmodule

`default_nettype wire

/* dv/tb_desc_dma_checks.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random source and compare tasks for the descriptor DMA testbench.
// Included inside the testbench module, next to end_with_failure.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_DESC_DMA_CHECKS_SVH
`define TB_DESC_DMA_CHECKS_SVH

// 32 bit LCG, every model keeps its own state
function automatic logic [31:0] lcg_step(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
endfunction

// pick in lo..hi, low LCG bits are weak so they are dropped
function automatic int rand_range(inout logic [31:0] state, input int lo, input int hi);
    logic [31:0] r;
    r = lcg_step(state);
    return lo + int'(r >> 8) % (hi - lo + 1);
endfunction

task automatic compare_burst(input desc_dma_pkg::burst_req_t got,
                             input desc_dma_pkg::burst_req_t exp);
    if (got !== exp) begin
        $display("** Error at %0t: dma_req_o = %h, expected %h", $time, got, exp);
        end_with_failure();
    end
endtask

task automatic compare_wb_addr(input desc_dma_pkg::addr_t got,
                               input desc_dma_pkg::addr_t exp);
    if (got !== exp) begin
        $display("** Error at %0t: mem_wb_addr_o = %h, expected %h", $time, got, exp);
        end_with_failure();
    end
endtask

task automatic compare_wb_flags(input logic [`DESC_FLAGS_W-1:0] got,
                                input logic [`DESC_FLAGS_W-1:0] exp);
    if (got !== exp) begin
        $display("** Error at %0t: mem_wb_data_o = %h, expected %h", $time, got, exp);
        end_with_failure();
    end
endtask

// single status or strobe bit
task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end_with_failure();
    end
endtask

task automatic compare_irq_count(input int got, input int exp);
    if (got != exp) begin
        $display("** Error at %0t: irq_o pulses = %0d, expected %0d", $time, got, exp);
        end_with_failure();
    end
endtask

`endif

/* dv/tb_desc_dma.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the descriptor DMA frontend. Random chains in a sparse memory
// model, random read, backend and write-back stalls, in-order scoreboard.
// Run it through the Makefile. SEED overrides the generator seed.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "desc_dma_consts.svh"

module tb_desc_dma #(
    parameter logic [31:0] SEED = 32'd71468
);

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CHAINS   = 12;
    // writes issued back to back so the address queue has to fill
    localparam int BURST_WRITES = `DESC_ADDR_Q_DEPTH + 3;
    localparam int WAIT_LIMIT   = 2000;
    localparam int DRAIN_LIMIT  = 20000;
    localparam int QUIET_CYCLES = 20;

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      desc_addr_we_i;
    desc_dma_pkg::addr_t       desc_addr_i;
    logic                      queue_full_o;
    logic                      busy_o;
    logic                      mem_rd_valid_o;
    desc_dma_pkg::addr_t       mem_rd_addr_o;
    logic                      mem_rd_ready_i;
    logic                      mem_rd_rsp_valid_i;
    desc_dma_pkg::descriptor_t mem_rd_rsp_i;
    logic                      mem_wb_valid_o;
    desc_dma_pkg::addr_t       mem_wb_addr_o;
    logic [`DESC_FLAGS_W-1:0]  mem_wb_data_o;
    logic                      mem_wb_ready_i;
    logic                      dma_req_valid_o;
    desc_dma_pkg::burst_req_t  dma_req_o;
    logic                      dma_req_ready_i;
    logic                      dma_done_i;
    logic                      irq_o;

    // sparse descriptor memory keyed by descriptor address
    desc_dma_pkg::descriptor_t mem_model [desc_dma_pkg::addr_t];
    desc_dma_pkg::addr_t       head_addr [NUM_CHAINS];
    // scoreboard filled in address write order
    desc_dma_pkg::burst_req_t  exp_burst [$];
    desc_dma_pkg::pending_t    exp_done [$];
    int                        total_desc;
    int                        exp_irq_count;
    int                        burst_count;
    int                        wb_count;
    int                        irq_count;
    logic                      saw_full;

    desc_dma_top dut_i (.*);

    task automatic end_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "tb_desc_dma_checks.svh"

    // chains of 1 to 4 descriptors at random 16 byte aligned addresses
    task automatic build_chains(inout logic [31:0] seed);
        desc_dma_pkg::descriptor_t d;
        desc_dma_pkg::addr_t       a;
        desc_dma_pkg::addr_t       prev;
        logic [31:0]               r;
        int                        len;
        total_desc = 0;
        for (int c = 0; c < NUM_CHAINS; c++) begin
            len  = rand_range(seed, 1, 4);
            prev = `DESC_END_OF_CHAIN;
            // built tail first so each link already knows its successor
            for (int k = 0; k < len; k++) begin
                do begin
                    a = lcg_step(seed) << 4;
                end while (mem_model.exists(a));
                r          = lcg_step(seed);
                d.flags    = r[31:24];
                d.length   = r[23:0];
                d.next     = prev;
                d.src_addr = lcg_step(seed);
                d.dst_addr = lcg_step(seed);
                mem_model[a] = d;
                prev = a;
            end
            head_addr[c] = prev;
            total_desc += len;
        end
    endtask

    // walk one chain through the memory model and queue what it must produce
    task automatic expect_chain(input desc_dma_pkg::addr_t head);
        desc_dma_pkg::descriptor_t d;
        desc_dma_pkg::pending_t    p;
        desc_dma_pkg::addr_t       a;
        a = head;
        while (a != `DESC_END_OF_CHAIN) begin
            d                = mem_model[a];
            p.burst.src_addr = d.src_addr;
            p.burst.dst_addr = d.dst_addr;
            p.burst.length   = d.length;
            p.desc_addr      = a;
            p.irq            = d.flags[`DESC_IRQ_BIT];
            exp_burst.push_back(p.burst);
            exp_done.push_back(p);
            if (p.irq) begin
                exp_irq_count++;
            end
            a = d.next;
        end
    endtask

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    initial begin : stimulus
        logic [31:0] seed;
        int          gap;
        int          tmo;
        seed           = SEED;
        rst_n_i        = 1'b0;
        desc_addr_we_i = 1'b0;
        desc_addr_i    = '0;
        saw_full       = 1'b0;
        exp_irq_count  = 0;
        build_chains(seed);
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        compare_bit("mem_rd_valid_o", mem_rd_valid_o, 1'b0);
        compare_bit("dma_req_valid_o", dma_req_valid_o, 1'b0);
        compare_bit("mem_wb_valid_o", mem_wb_valid_o, 1'b0);
        compare_bit("irq_o", irq_o, 1'b0);
        compare_bit("busy_o", busy_o, 1'b0);
        compare_bit("queue_full_o", queue_full_o, 1'b0);
        for (int c = 0; c < NUM_CHAINS; c++) begin
            // software only writes while the queue has room
            tmo = 0;
            while (queue_full_o) begin
                saw_full = 1'b1;
                @(negedge clk_i);
                tmo++;
                if (tmo > WAIT_LIMIT) begin
                    $display("queue_full_o stayed high, the fetcher stopped taking chains");
                    end_with_failure();
                end
            end
            desc_addr_we_i = 1'b1;
            desc_addr_i    = head_addr[c];
            expect_chain(head_addr[c]);
            @(negedge clk_i);
            desc_addr_we_i = 1'b0;
            // the address just queued keeps the frontend busy
            compare_bit("busy_o", busy_o, 1'b1);
            gap = (c < BURST_WRITES) ? 0 : rand_range(seed, 0, 40);
            repeat (gap) @(negedge clk_i);
        end
        tmo = 0;
        while (wb_count < total_desc) begin
            @(posedge clk_i);
            tmo++;
            if (tmo > DRAIN_LIMIT) begin
                $display("timeout, %0d of %0d descriptors completed", wb_count, total_desc);
                end_with_failure();
            end
        end
        tmo = 0;
        while (busy_o) begin
            @(negedge clk_i);
            tmo++;
            if (tmo > WAIT_LIMIT) begin
                $display("busy_o stayed high after the last completion");
                end_with_failure();
            end
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk_i);
            compare_bit("busy_o", busy_o, 1'b0);
        end
        compare_irq_count(irq_count, exp_irq_count);
        if (!saw_full) begin
            $display("queue_full_o never rose although writes outran the chains");
            end_with_failure();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    // descriptor reads with 1 to 5 cycles latency and one outstanding
    initial begin : read_model
        logic [31:0]         seed;
        int                  rd_delay;
        desc_dma_pkg::addr_t rd_addr;
        seed               = SEED ^ 32'h0000_00a5;
        rd_delay           = 0;
        rd_addr            = '0;
        mem_rd_ready_i     = 1'b0;
        mem_rd_rsp_valid_i = 1'b0;
        mem_rd_rsp_i       = '0;
        forever begin
            @(negedge clk_i);
            mem_rd_rsp_valid_i = 1'b0;
            if (rd_delay > 0) begin
                rd_delay--;
                if (rd_delay == 0) begin
                    mem_rd_rsp_i       = mem_model[rd_addr];
                    mem_rd_rsp_valid_i = 1'b1;
                end
            end else begin
                mem_rd_ready_i = (rand_range(seed, 0, 3) != 0);
                if (mem_rd_valid_o && mem_rd_ready_i) begin
                    if (!mem_model.exists(mem_rd_addr_o)) begin
                        $display("descriptor read from %h, where no descriptor lives",
                                 mem_rd_addr_o);
                        end_with_failure();
                    end
                    rd_addr  = mem_rd_addr_o;
                    rd_delay = rand_range(seed, 1, 5);
                end
            end
        end
    end

    // backend takes one burst and finishes it 1 to 6 cycles later
    initial begin : backend_model
        logic [31:0] seed;
        int          done_delay;
        seed            = SEED ^ 32'h0000_5a00;
        done_delay      = 0;
        burst_count     = 0;
        dma_req_ready_i = 1'b0;
        dma_done_i      = 1'b0;
        forever begin
            @(negedge clk_i);
            dma_done_i = 1'b0;
            if (done_delay > 0) begin
                done_delay--;
                dma_done_i = (done_delay == 0);
            end else begin
                dma_req_ready_i = (rand_range(seed, 0, 2) != 0);
                if (dma_req_valid_o && dma_req_ready_i) begin
                    if (exp_burst.size() == 0) begin
                        $display("backend request with no descriptor left to serve");
                        end_with_failure();
                    end
                    compare_burst(dma_req_o, exp_burst.pop_front());
                    burst_count++;
                    done_delay = rand_range(seed, 1, 6);
                end
            end
        end
    end

    // marker write-back that also watches the irq following it
    initial begin : writeback_model
        logic [31:0]               seed;
        logic                      irq_due;
        desc_dma_pkg::pending_t    entry;
        desc_dma_pkg::descriptor_t d;
        seed           = SEED ^ 32'h00c3_0000;
        irq_due        = 1'b0;
        wb_count       = 0;
        irq_count      = 0;
        mem_wb_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            // irq sits in the cycle right after an accepted write-back
            compare_bit("irq_o", irq_o, irq_due);
            if (irq_o) begin
                irq_count++;
            end
            irq_due        = 1'b0;
            mem_wb_ready_i = (rand_range(seed, 0, 2) != 0);
            if (mem_wb_valid_o && mem_wb_ready_i) begin
                if (exp_done.size() == 0 || wb_count >= burst_count) begin
                    $display("write-back with no finished burst behind it");
                    end_with_failure();
                end
                entry = exp_done.pop_front();
                compare_wb_addr(mem_wb_addr_o, entry.desc_addr);
                compare_wb_flags(mem_wb_data_o, `DESC_DONE_MARK);
                d       = mem_model[mem_wb_addr_o];
                d.flags = mem_wb_data_o;
                mem_model[mem_wb_addr_o] = d;
                irq_due = entry.irq;
                wb_count++;
            end
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
+incdir+dv
src/desc_dma_pkg.sv
src/desc_queue.sv
src/desc_fetcher.sv
src/desc_completion.sv
src/desc_dma_top.sv
dv/tb_desc_dma.sv

/* Makefile */
# Verilator flow for the descriptor DMA frontend

TOP       ?= tb_desc_dma
RTL_TOP   ?= desc_dma_top
SEED      ?= 71468
LOG       ?= sim.log
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator

VFLAGS = --timing --assert --timescale 1ns/1ps -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
